// ==== include/acq_params.svh ====
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// circular buffer geometry

`define ACQ_ADDR_W      6                       // buffer address bits
`define ACQ_DEPTH       (1 << `ACQ_ADDR_W)      // 64 words in the buffer

// words written after the trigger word, before the buffer freezes
`define ACQ_POST_TRIG   16

////////////////////////////////////////////////////////////////////////////
// sample and packed word widths

`define ACQ_SAMPLE_W    12                      // one adc sample
`define ACQ_HALF_W      (`ACQ_SAMPLE_W + 1)     // sample plus over-range bit
`define ACQ_WORD_W      (2 * `ACQ_HALF_W)       // two halves, 26 bits

`endif

// ==== verilog/acq_pkg.sv ====
`default_nettype none

`include "acq_params.svh"

package acq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data types

    // one adc conversion result
    typedef logic [`ACQ_SAMPLE_W-1:0] adc_sample_t;

    // two samples per adc_clk, first sample in the low half
    //   [0]     first over-range
    //   [12:1]  first sample
    //   [13]    second over-range
    //   [25:14] second sample
    typedef logic [`ACQ_WORD_W-1:0] packed_word_t;

    // circular buffer address, wraps on overflow
    typedef logic [`ACQ_ADDR_W-1:0] buf_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // readout sequencer states

    typedef enum logic [2:0] {
        IDLE,       // acquisition off
        ARMED,      // writing, waiting for a trigger
        POST,       // counting post-trigger writes
        READ,       // buffer frozen, issuing reads
        DONE        // readout finished, wait for acq_en low
    } rd_state_t;

endpackage

`default_nettype wire

// ==== verilog/adc_sample_source.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_sample_source (
    input  wire                   adc_clk,
    input  wire                   rst_n,
    input  wire acq_pkg::packed_word_t adc_word,     // packed pair from the adc capture
    input  wire                   acq_en,            // level, writing enabled
    input  wire                   freeze,            // level from readout, stop writing
    input  wire                   use_dummy_data,    // counter pattern instead of adc
    input  wire                   dummy_reset_mode,  // restart counter on each trigger
    input  wire                   trig_pulse,        // one-cycle trigger strobe
    output logic                  wr_en,
    output acq_pkg::buf_addr_t    wr_addr,
    output acq_pkg::packed_word_t wr_data
);

    import acq_pkg::*;

    logic         wr_ok;        // word of this cycle gets written next cycle
    adc_sample_t  dummy_cnt;    // counter for the integrity pattern
    adc_sample_t  dummy_cur;    // counter value used by this cycle's word
    packed_word_t src_word;     // selected source before the output register

    assign wr_ok = acq_en && !freeze;

    ////////////////////////////////////////////////////////////////////////////
    // dummy data counter

    // a trigger in reset mode forces zero into the word sampled at the pulse,
    // so the trigger word itself carries count 0
    assign dummy_cur = (trig_pulse && dummy_reset_mode) ? '0 : dummy_cnt;

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            dummy_cnt <= '0;
        end else if (use_dummy_data && wr_ok) begin
            dummy_cnt <= dummy_cur + 1'b1;      // one step per enabled cycle
        end else begin
            dummy_cnt <= dummy_cur;             // hold, or take the trigger clear
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // source select and write data register

    // dummy word: inverted count high, count low, over-range bits zero
    assign src_word = use_dummy_data ? {~dummy_cur, 1'b0, dummy_cur, 1'b0}
                                     : adc_word;

    always_ff @(posedge adc_clk) begin
        wr_data <= src_word;                    // input of cycle n lands with strobe n+1
    end

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= wr_ok;                     // one cycle behind acq_en/freeze
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // circular write address

    always_ff @(posedge adc_clk) begin
        if (!rst_n || !acq_en) begin
            wr_addr <= '0;                      // parked at zero while disabled
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;          // wraps at the buffer depth
        end
    end

    // every write moves the pointer on by one, unless acquisition stops
    a_wr_addr_step : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        (wr_en && acq_en) |=> (wr_addr == buf_addr_t'($past(wr_addr) + 1'b1))
    ) else $error("wr_addr did not advance by one after a write");

endmodule

`default_nettype wire

// ==== verilog/circ_buf_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "acq_params.svh"

module circ_buf_ram (
    input  wire                        adc_clk,
    input  wire                        wr_en,       // write strobe from the producer
    input  wire acq_pkg::buf_addr_t    wr_addr,
    input  wire acq_pkg::packed_word_t wr_data,
    input  wire                        rd_en,       // read strobe from the sequencer
    input  wire acq_pkg::buf_addr_t    rd_addr,
    output acq_pkg::packed_word_t      rd_q         // one cycle after rd_en
);

    import acq_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // storage

    // simple dual port, maps onto a single block ram
    packed_word_t mem [`ACQ_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // write port

    always_ff @(posedge adc_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;            // lands at the strobe's edge
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port

    // registered output, holds its last value between reads
    always_ff @(posedge adc_clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trig_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "acq_params.svh"

module trig_readout (
    input  wire                        adc_clk,
    input  wire                        rst_n,
    input  wire                        acq_en,
    input  wire                        trig_pulse,
    input  wire                        wr_en,        // producer write strobe
    input  wire acq_pkg::buf_addr_t    wr_addr,      // address of the current write
    output logic                       freeze,       // stops the producer
    output logic                       rd_en,
    output acq_pkg::buf_addr_t         rd_addr,
    input  wire acq_pkg::packed_word_t rd_q,
    output logic                       rd_valid,
    output acq_pkg::packed_word_t      rd_data,
    output logic                       rd_last,
    output logic                       capture_done
);

    import acq_pkg::*;

    localparam int        POST_CNT_W = $clog2(`ACQ_POST_TRIG + 1);
    localparam buf_addr_t LAST_IDX   = buf_addr_t'(`ACQ_DEPTH - 1);

    rd_state_t             state;
    logic [POST_CNT_W-1:0] post_cnt;    // writes left before the final one
    buf_addr_t             rd_cnt;      // reads issued so far
    logic                  post_end;    // final post-trigger write this cycle
    logic                  read_end;    // final read address this cycle
    logic                  v1;          // valid, aligned with rd_q
    logic                  l1;          // last, aligned with rd_q

    assign post_end = (state == POST) && wr_en && (post_cnt == '0);
    assign read_end = (state == READ) && (rd_cnt == LAST_IDX);
    assign rd_en    = (state == READ);      // one read per cycle, no back-pressure

    ////////////////////////////////////////////////////////////////////////////
    // sequencer

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (acq_en) state <= ARMED;
                end
                ARMED: begin
                    if (!acq_en) begin
                        state <= IDLE;
                    end else if (trig_pulse) begin
                        state <= POST;      // pulse outside ARMED is ignored
                    end
                end
                POST: begin
                    if (!acq_en) begin
                        state <= IDLE;      // capture abandoned
                    end else if (post_end) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (read_end) state <= DONE;
                end
                DONE: begin
                    if (!acq_en) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // post-trigger count and freeze

    // the trigger word's own write takes the first decrement
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            post_cnt <= '0;
        end else if (state == ARMED) begin
            post_cnt <= POST_CNT_W'(`ACQ_POST_TRIG);
        end else if (state == POST && wr_en && post_cnt != '0) begin
            post_cnt <= post_cnt - 1'b1;
        end
    end

    // wr_en is registered in the producer, so freeze has to be up
    // during the final write to keep the next one out
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            freeze <= 1'b0;
        end else if (state == POST && wr_en && post_cnt == POST_CNT_W'(1)) begin
            freeze <= 1'b1;
        end else if (state == IDLE) begin
            freeze <= 1'b0;                 // release once acq_en has dropped
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read address, oldest first

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            rd_addr <= '0;
            rd_cnt  <= '0;
        end else if (post_end) begin
            rd_addr <= buf_addr_t'(wr_addr + 1'b1);     // slot after the last write
            rd_cnt  <= '0;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;      // wraps through the whole buffer
            rd_cnt  <= rd_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output pipe, ram stage then output register

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            v1       <= 1'b0;
            l1       <= 1'b0;
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            v1       <= rd_en;
            l1       <= read_end;
            rd_valid <= v1;
            rd_last  <= l1;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (v1) rd_data <= rd_q;            // hold last word between bursts
    end

    always_ff @(posedge adc_clk) begin
        if (!rst_n || !acq_en) begin
            capture_done <= 1'b0;
        end else if (rd_last) begin
            capture_done <= 1'b1;           // stays up until acq_en falls
        end
    end

    // buffer is frozen for the whole readout
    a_no_rd_wr_overlap : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        !(rd_en && wr_en)
    ) else $error("read and write strobes high in the same cycle");

    a_last_with_valid : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        rd_last |-> rd_valid
    ) else $error("rd_last without rd_valid");

endmodule

`default_nettype wire

// ==== verilog/adc_acq_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_acq_top (
    input  wire                        adc_clk,
    input  wire                        rst_n,
    input  wire acq_pkg::packed_word_t adc_word,
    input  wire                        acq_en,
    input  wire                        use_dummy_data,
    input  wire                        dummy_reset_mode,
    input  wire                        trig_pulse,
    output wire                        rd_valid,
    output wire acq_pkg::packed_word_t rd_data,
    output wire                        rd_last,
    output wire                        capture_done
);

    import acq_pkg::*;

    // producer side
    wire               wr_en;
    buf_addr_t         wr_addr;
    packed_word_t      wr_data;
    // readout side
    wire               freeze;
    wire               rd_en;
    buf_addr_t         rd_addr;
    packed_word_t      rd_q;

    ////////////////////////////////////////////////////////////////////////////
    // sample producer, fills the buffer

    adc_sample_source src0 (
        .adc_clk          (adc_clk),
        .rst_n            (rst_n),
        .adc_word         (adc_word),
        .acq_en           (acq_en),
        .freeze           (freeze),
        .use_dummy_data   (use_dummy_data),
        .dummy_reset_mode (dummy_reset_mode),
        .trig_pulse       (trig_pulse),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data)
    );

    circ_buf_ram buf0 (
        .adc_clk (adc_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_q    (rd_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // trigger handling and readout

    trig_readout trg0 (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .acq_en       (acq_en),
        .trig_pulse   (trig_pulse),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .freeze       (freeze),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_q         (rd_q),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_last      (rd_last),
        .capture_done (capture_done)
    );

endmodule

`default_nettype wire

// ==== dv/adc_acq_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "acq_params.svh"

module adc_acq_tb;

    import acq_pkg::*;

    localparam int REC_W     = 5;                                  // fields per trace record
    localparam int MAX_REC   = 16;
    localparam int TRIG_IDX  = `ACQ_DEPTH - `ACQ_POST_TRIG - 1;   // trigger slot in readout
    localparam int DONE_WAIT = 300;                                // trigger to capture_done

    logic         adc_clk;
    logic         rst_n;
    packed_word_t adc_word;
    logic         acq_en;
    logic         use_dummy_data;
    logic         dummy_reset_mode;
    logic         trig_pulse;
    logic         rd_valid;
    packed_word_t rd_data;
    logic         rd_last;
    logic         capture_done;

    logic [15:0]  trace_mem [REC_W*MAX_REC];
    integer       seed;
    int           err_cnt;
    int           tests_run;
    int           tests_failed;
    int           rec;

    ////////////////////////////////////////////////////////////////////////////
    // reference model state

    packed_word_t written_q [$];    // words the buffer should take, write order
    packed_word_t got_q [$];        // readout as seen on rd_data
    logic         last_q [$];
    adc_sample_t  dcnt_m;           // expected dummy counter
    adc_sample_t  adc_base;
    logic         armed_m;
    logic         post_m;
    logic         frozen_m;
    int           post_left_m;
    int           trig_idx_m;       // index of the trigger word in written_q

    initial begin
        adc_clk = 1'b0;
        forever #20 adc_clk = ~adc_clk;     // 40 ns
    end

    adc_acq_top dut0 (
        .adc_clk          (adc_clk),
        .rst_n            (rst_n),
        .adc_word         (adc_word),
        .acq_en           (acq_en),
        .use_dummy_data   (use_dummy_data),
        .dummy_reset_mode (dummy_reset_mode),
        .trig_pulse       (trig_pulse),
        .rd_valid         (rd_valid),
        .rd_data          (rd_data),
        .rd_last          (rd_last),
        .capture_done     (capture_done)
    );

    // outputs are registers, stable at the falling edge
    always @(negedge adc_clk) begin
        if (rd_valid) begin
            got_q.push_back(rd_data);
            last_q.push_back(rd_last);
        end
        if (rd_last && !rd_valid) begin
            $display("ERR %0t: rd_last high without rd_valid", $time);
            err_cnt++;
        end
    end

    function automatic packed_word_t next_adc_word();
        logic [31:0] r;
        adc_sample_t s0;
        adc_sample_t s1;
        r  = $random(seed);
        s0 = adc_base + adc_sample_t'(r[7:0]);
        s1 = adc_base + adc_sample_t'(r[15:8]);
        return {s1, r[17], s0, r[16]};      // over-range bits random too
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // one clock of stimulus, model updated with what the DUT samples next edge

    task automatic drive_cycle(input logic en, input logic pulse);
        adc_sample_t  cur;
        packed_word_t exp_word;
        logic         wr_ok;
        @(negedge adc_clk);
        acq_en     = en;
        trig_pulse = pulse;
        adc_word   = next_adc_word();
        wr_ok      = en && !frozen_m;
        cur        = (pulse && dummy_reset_mode) ? '0 : dcnt_m;  // trigger word gets zero
        exp_word   = use_dummy_data ? {~cur, 1'b0, cur, 1'b0} : adc_word;
        dcnt_m     = (use_dummy_data && wr_ok) ? adc_sample_t'(cur + 1'b1) : cur;
        if (wr_ok) begin
            written_q.push_back(exp_word);
            if (post_m) begin
                post_left_m--;              // one of the post-trigger writes
                if (post_left_m == 0) begin
                    post_m   = 1'b0;
                    frozen_m = 1'b1;
                end
            end
        end
        if (pulse && en && armed_m) begin
            armed_m     = 1'b0;
            post_m      = 1'b1;
            post_left_m = `ACQ_POST_TRIG;
            trig_idx_m  = written_q.size() - 1;
        end
        if (!en) begin
            armed_m  = 1'b0;
            post_m   = 1'b0;
            frozen_m = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, err_cnt - errs_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // idle after reset, a stray trigger with acq_en low is ignored
    task automatic check_idle_after_reset();
        int errs;
        int n;
        errs = err_cnt;
        for (n = 0; n < 8; n++) begin
            drive_cycle(1'b0, n == 3);
            if (rd_valid || rd_last || capture_done) begin
                $display("ERR %0t: output active after reset with acq_en low", $time);
                err_cnt++;
            end
        end
        report_test("reset idle", errs);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one capture from a trace record

    task automatic run_capture(input int r);
        logic [15:0]  mode;
        logic [11:0]  first_exp;
        int           pre;
        int           errs;
        int           k;
        int           i;
        int           lat;
        int           k_last;
        int           k_done;
        int           base_i;
        packed_word_t w;
        adc_sample_t  lo;
        adc_sample_t  prev_lo;
        errs             = err_cnt;
        mode             = trace_mem[r*REC_W];
        dummy_reset_mode = trace_mem[r*REC_W + 1][0];
        pre              = trace_mem[r*REC_W + 2];
        adc_base         = trace_mem[r*REC_W + 3][11:0];
        first_exp        = trace_mem[r*REC_W + 4][11:0];
        use_dummy_data   = (mode == 16'd1);
        written_q.delete();
        got_q.delete();
        last_q.delete();
        armed_m = 1'b1;                     // consumer arms as acq_en rises
        repeat (pre) drive_cycle(1'b1, 1'b0);
        drive_cycle(1'b1, 1'b1);            // trigger word
        lat    = -1;
        k_last = -1;
        k_done = -1;
        k      = 0;
        while (k_done < 0 && k < DONE_WAIT) begin
            k++;
            drive_cycle(1'b1, (mode == 16'd2) && (k == 5 || k == 30));  // POST, READ
            if (rd_valid && lat < 0) lat = k;
            if (rd_last && k_last < 0) k_last = k;
            if (capture_done) k_done = k;
        end
        if (k_done < 0) begin
            $display("capture_done never rose within %0d cycles of the trigger", DONE_WAIT);
            $display("=== FAIL ===");
            $finish;
        end
        repeat (3) begin
            drive_cycle(1'b1, 1'b0);
            if (!capture_done) begin
                $display("ERR %0t: capture_done dropped while acq_en high", $time);
                err_cnt++;
            end
        end
        if (lat != `ACQ_POST_TRIG + 4) begin
            $display("ERR %0t: trigger to rd_valid took %0d cycles", $time, lat);
            err_cnt++;
        end
        if (k_done != k_last + 1) begin
            $display("ERR %0t: capture_done not in the cycle after rd_last", $time);
            err_cnt++;
        end
        base_i = trig_idx_m + `ACQ_POST_TRIG - `ACQ_DEPTH + 1;     // oldest word kept
        if (got_q.size() != `ACQ_DEPTH) begin
            $display("ERR %0t: %0d words read out", $time, got_q.size());
            err_cnt++;
        end else if (base_i < 0) begin
            $display("trace record %0d leaves the buffer part empty", r);
            err_cnt++;
        end else begin
            for (i = 0; i < `ACQ_DEPTH; i++) begin
                if (got_q[i] !== written_q[base_i + i]) begin
                    $display("ERR %0t: word %0d is %h, expected %h", $time, i, got_q[i],
                             written_q[base_i + i]);
                    err_cnt++;
                end
                if (last_q[i] !== (i == `ACQ_DEPTH - 1)) begin
                    $display("ERR %0t: rd_last wrong on word %0d", $time, i);
                    err_cnt++;
                end
            end
            if (got_q[TRIG_IDX] !== written_q[trig_idx_m]) begin
                $display("ERR %0t: trigger word not at index %0d", $time, TRIG_IDX);
                err_cnt++;
            end
            if (mode == 16'd1) begin
                prev_lo = '0;
                for (i = 0; i < `ACQ_DEPTH; i++) begin
                    w  = got_q[i];
                    lo = w[12:1];
                    if ((w[25:14] !== ~lo) || w[13] || w[0]) begin
                        $display("ERR %0t: dummy word %0d malformed %h", $time, i, w);
                        err_cnt++;
                    end
                    if (i > 0 && !(dummy_reset_mode && i == TRIG_IDX) &&
                        lo !== adc_sample_t'(prev_lo + 1'b1)) begin
                        $display("ERR %0t: dummy count breaks at word %0d", $time, i);
                        err_cnt++;
                    end
                    prev_lo = lo;
                end
                if (dummy_reset_mode && got_q[TRIG_IDX][12:1] !== 12'd0) begin
                    $display("ERR %0t: trigger word count not zero", $time);
                    err_cnt++;
                end
                if (got_q[0][12:1] !== first_exp) begin
                    $display("ERR %0t: first count %h, expected %h", $time, got_q[0][12:1],
                             first_exp);
                    err_cnt++;
                end
            end
        end
        // acq_en low clears capture_done
        k = 0;
        do begin
            drive_cycle(1'b0, 1'b0);
            k++;
        end while (capture_done && k < 4);
        if (capture_done) begin
            $display("ERR %0t: capture_done still high after acq_en fell", $time);
            err_cnt++;
        end
        repeat (3) drive_cycle(1'b0, 1'b0);        // sequencer back to IDLE
        report_test($sformatf("mode %0d reset %0d pre %0d", mode, dummy_reset_mode, pre), errs);
    endtask

    initial begin
        seed             = 32'h29f7_e02d;
        err_cnt          = 0;
        tests_run        = 0;
        tests_failed     = 0;
        rst_n            = 1'b0;
        adc_word         = '0;
        acq_en           = 1'b0;
        use_dummy_data   = 1'b0;
        dummy_reset_mode = 1'b0;
        trig_pulse       = 1'b0;
        dcnt_m           = '0;
        adc_base         = '0;
        armed_m          = 1'b0;
        post_m           = 1'b0;
        frozen_m         = 1'b0;
        post_left_m      = 0;
        trig_idx_m       = 0;
        $readmemh("dv/acq_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0])) begin
            $display("trace file dv/acq_trace.txt could not be read");
            $display("=== FAIL ===");
            $finish;
        end
        repeat (3) @(negedge adc_clk);
        rst_n = 1'b1;
        check_idle_after_reset();
        rec = 0;
        while (rec < MAX_REC && trace_mem[rec*REC_W] !== 16'h00ff) begin
            run_capture(rec);
            rec++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0 && rec > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== adc_acq_top.f ====
+incdir+include
verilog/acq_pkg.sv
verilog/adc_sample_source.sv
verilog/circ_buf_ram.sv
verilog/trig_readout.sv
verilog/adc_acq_top.sv
dv/adc_acq_tb.sv

// ==== dv/acq_trace.txt ====
// mode (0 adc, 1 dummy, 2 adc plus extra triggers), dummy_reset_mode, pre-trigger cycles,
// adc base value, expected low sample of the first readout word (dummy mode), all hex
0  0 32 100 000
0  0 2f 800 000
1  0 3c 000 00d
1  1 46 000 064
1  0 64 000 046
2  0 37 a5a 000
1  1 2f 000 086
0  1 40 3c0 000
1  0 30 000 001
// end marker
ff 0 00 000 000
